// File: Makefile
TOP := rob_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o rob_sim
	out=$$(./obj_dir/rob_sim); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// File: dv/rob_assert.sv
module rob_assert (
  input logic clock,
  input logic reset_n,
  input logic req_i,
  input logic ack_i,
  input logic full_i,
  input logic empty_i,
  input logic pop_i,
  input logic flush_i,
  input logic retire_valid_i
);

  timeunit 1ns;
  timeprecision 1ps;

  // Ack only while the request is up or has just dropped
  ack_needs_req: assert property (@(posedge clock) disable iff (!reset_n)
    ack_i |-> (req_i || $past(req_i)))
    else $error("dispatch ack without a request");

  // A reservation while full would wrap the occupancy count
  full_held: assert property (@(posedge clock) disable iff (!reset_n)
    (full_i && !pop_i && !flush_i) |=> full_i)
    else $error("buffer left full without a pop or a flush");

  // Retire strobe never follows an empty buffer
  retire_after_entry: assert property (@(posedge clock) disable iff (!reset_n)
    empty_i |=> !retire_valid_i)
    else $error("retire strobe one cycle after an empty buffer");

endmodule

bind rob_top rob_assert assert_i (
  .clock         (clock),
  .reset_n       (reset_n),
  .req_i         (disp_req_i),
  .ack_i         (disp_ack_o),
  .full_i        (full_o),
  .empty_i       (empty_o),
  .pop_i         (retire_pop),
  .flush_i       (flush_i),
  .retire_valid_i(retire_valid_o)
);

// File: dv/rob_checker.sv
module rob_checker (
  input logic           clock,
  input logic           reset_n,
  input logic           disp_ack_i,
  input rob_pkg::slot_t disp_slot_i,
  input logic           full_i,
  input logic           empty_i,
  input rob_pkg::data_t value_a_i,
  input rob_pkg::data_t value_b_i,
  input logic           ready_a_i,
  input logic           ready_b_i,
  input rob_pkg::slot_t tag_a_i,
  input rob_pkg::slot_t tag_b_i,
  input logic           retire_valid_i,
  input rob_pkg::areg_t retire_reg_i,
  input rob_pkg::data_t retire_data_i
);

  timeunit 1ns;
  timeprecision 1ps;

  int errors = 0;
  int checks = 0;
  int tests = 0;
  int test_errors = 0;

  rob_pkg::areg_t exp_reg_q[$];
  rob_pkg::data_t exp_data_q[$];

  task automatic report_error(input string msg);
    $display("%s", msg);
    errors++;
    test_errors++;
  endtask

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      report_error($sformatf("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic expect_retire(input rob_pkg::areg_t reg_num, input rob_pkg::data_t data);
    exp_reg_q.push_back(reg_num);
    exp_data_q.push_back(data);
  endtask

  // Idle outputs right after reset
  task automatic check_reset_state();
    compare("disp_ack_o", 32'(disp_ack_i), 32'(0));
    compare("retire_valid_o", 32'(retire_valid_i), 32'(0));
    compare("empty_o", 32'(empty_i), 32'(1));
    compare("full_o", 32'(full_i), 32'(0));
  endtask

  task automatic check_slot(input rob_pkg::slot_t exp);
    compare("disp_slot_o", 32'(disp_slot_i), 32'(exp));
  endtask

  // Dispatch must be held off while the buffer is full
  task automatic check_stalled();
    checks++;
    if (!full_i) begin
      report_error("Buffer was not full before a dispatch that should stall");
    end
    if (disp_ack_i) begin
      report_error("Dispatch was acknowledged while the buffer was full");
    end
  endtask

  task automatic check_query(input logic [31:0] va, input logic ra, input logic [31:0] ta,
                             input logic [31:0] vb, input logic rb, input logic [31:0] tb);
    compare("value_a_o", value_a_i, va);
    compare("ready_a_o", 32'(ready_a_i), 32'(ra));
    compare("tag_a_o", 32'(tag_a_i), ta);
    compare("value_b_o", value_b_i, vb);
    compare("ready_b_o", 32'(ready_b_i), 32'(rb));
    compare("tag_b_o", 32'(tag_b_i), tb);
  endtask

  task automatic end_test();
    if (exp_reg_q.size() != 0) begin
      report_error($sformatf("%0d expected retirements never happened", exp_reg_q.size()));
      exp_reg_q.delete();
      exp_data_q.delete();
    end
    tests++;
    $display("Test %0d: %s (%0d errors)", tests, (test_errors == 0) ? "PASS" : "FAIL",
             test_errors);
    test_errors = 0;
  endtask

  // Retirements are compared in program order
  always @(negedge clock) begin
    if (reset_n && retire_valid_i) begin
      if (exp_reg_q.size() == 0) begin
        report_error($sformatf("Unexpected retirement of register %0d", retire_reg_i));
      end else begin
        compare("retire_reg_o", 32'(retire_reg_i), 32'(exp_reg_q.pop_front()));
        compare("retire_data_o", retire_data_i, exp_data_q.pop_front());
      end
    end
  end

endmodule

// File: dv/rob_tb.sv
module rob_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DEPTH = 16;
  localparam int TIMEOUT = 200;

  logic           clock;
  logic           reset_n;
  logic           disp_req_i;
  rob_pkg::areg_t disp_dest_i;
  logic           disp_dest_valid_i;
  logic           disp_ack_o;
  rob_pkg::slot_t disp_slot_o;
  logic           wb_valid_i;
  rob_pkg::slot_t wb_slot_i;
  rob_pkg::data_t wb_data_i;
  logic           flush_i;
  rob_pkg::slot_t flush_slot_i;
  rob_pkg::slot_t query_slot_i;
  rob_pkg::areg_t src_a_i;
  rob_pkg::areg_t src_b_i;
  rob_pkg::data_t value_a_o;
  rob_pkg::data_t value_b_o;
  logic           ready_a_o;
  logic           ready_b_o;
  rob_pkg::slot_t tag_a_o;
  rob_pkg::slot_t tag_b_o;
  logic           retire_valid_o;
  rob_pkg::areg_t retire_reg_o;
  rob_pkg::data_t retire_data_o;
  logic           full_o;
  logic           empty_o;

  logic           abort;
  logic           bg_busy;
  rob_pkg::areg_t bg_dest;
  logic           bg_dest_valid;
  rob_pkg::slot_t bg_slot;

  rob_top #(
    .DEPTH(DEPTH)
  ) dut_i (
    .clock            (clock),
    .reset_n          (reset_n),
    .disp_req_i       (disp_req_i),
    .disp_dest_i      (disp_dest_i),
    .disp_dest_valid_i(disp_dest_valid_i),
    .disp_ack_o       (disp_ack_o),
    .disp_slot_o      (disp_slot_o),
    .wb_valid_i       (wb_valid_i),
    .wb_slot_i        (wb_slot_i),
    .wb_data_i        (wb_data_i),
    .flush_i          (flush_i),
    .flush_slot_i     (flush_slot_i),
    .query_slot_i     (query_slot_i),
    .src_a_i          (src_a_i),
    .src_b_i          (src_b_i),
    .value_a_o        (value_a_o),
    .value_b_o        (value_b_o),
    .ready_a_o        (ready_a_o),
    .ready_b_o        (ready_b_o),
    .tag_a_o          (tag_a_o),
    .tag_b_o          (tag_b_o),
    .retire_valid_o   (retire_valid_o),
    .retire_reg_o     (retire_reg_o),
    .retire_data_o    (retire_data_o),
    .full_o           (full_o),
    .empty_o          (empty_o)
  );

  rob_checker chk_i (
    .clock         (clock),
    .reset_n       (reset_n),
    .disp_ack_i    (disp_ack_o),
    .disp_slot_i   (disp_slot_o),
    .full_i        (full_o),
    .empty_i       (empty_o),
    .value_a_i     (value_a_o),
    .value_b_i     (value_b_o),
    .ready_a_i     (ready_a_o),
    .ready_b_i     (ready_b_o),
    .tag_a_i       (tag_a_o),
    .tag_b_i       (tag_b_o),
    .retire_valid_i(retire_valid_o),
    .retire_reg_i  (retire_reg_o),
    .retire_data_i (retire_data_o)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  task automatic wait_ack(input logic level, output logic ok);
    int n;
    ok = 1'b0;
    n = 0;
    while (!ok && n < TIMEOUT) begin
      @(negedge clock);
      ok = (disp_ack_o == level);
      n++;
    end
  endtask

  task automatic dispatch(input rob_pkg::areg_t dest, input logic dest_valid,
                          input rob_pkg::slot_t slot, input logic expect_stall);
    logic ok;
    @(posedge clock);
    disp_req_i        <= 1'b1;
    disp_dest_i       <= dest;
    disp_dest_valid_i <= dest_valid;
    if (expect_stall) begin
      repeat (2) @(negedge clock);
      chk_i.check_stalled();
    end
    wait_ack(1'b1, ok);
    if (!ok) begin
      chk_i.report_error("Timed out waiting for the dispatch ack");
      abort = 1'b1;
    end else begin
      chk_i.check_slot(slot);
      @(posedge clock);
      disp_req_i <= 1'b0;
      wait_ack(1'b0, ok);
      if (!ok) begin
        chk_i.report_error("Timed out waiting for the dispatch ack to fall");
        abort = 1'b1;
      end
    end
  endtask

  task automatic writeback(input rob_pkg::slot_t slot, input rob_pkg::data_t data);
    @(posedge clock);
    wb_valid_i <= 1'b1;
    wb_slot_i  <= slot;
    wb_data_i  <= data;
    @(posedge clock);
    wb_valid_i <= 1'b0;
  endtask

  task automatic flush(input rob_pkg::slot_t slot);
    @(posedge clock);
    flush_i      <= 1'b1;
    flush_slot_i <= slot;
    @(posedge clock);
    flush_i <= 1'b0;
  endtask

  task automatic wait_empty();
    int n;
    n = 0;
    while (n < TIMEOUT) begin
      @(negedge clock);
      if (empty_o) begin
        break;
      end
      n++;
    end
    if (!empty_o) begin
      chk_i.report_error("Timed out waiting for the buffer to drain");
      abort = 1'b1;
    end
  endtask

  // A stalled dispatch must finish before the next ordering point
  task automatic wait_background();
    int n;
    n = 0;
    while (bg_busy && n < 2 * TIMEOUT + 10) begin
      @(posedge clock);
      n++;
    end
    if (bg_busy) begin
      chk_i.report_error("Timed out waiting for the stalled dispatch to finish");
      abort = 1'b1;
    end
  endtask

  initial begin
    int fd;
    int code;
    string line;
    byte cmd;
    logic [31:0] f0, f1, f2, f3, f4, f5, f6, f7, f8;
    disp_req_i        = 1'b0;
    disp_dest_i       = '0;
    disp_dest_valid_i = 1'b0;
    wb_valid_i        = 1'b0;
    wb_slot_i         = '0;
    wb_data_i         = '0;
    flush_i           = 1'b0;
    flush_slot_i      = '0;
    query_slot_i      = '0;
    src_a_i           = '0;
    src_b_i           = '0;
    reset_n           = 1'b0;
    abort             = 1'b0;
    bg_busy           = 1'b0;
    void'($urandom(72235));
    repeat (10) @(posedge clock);
    reset_n <= 1'b1;
    @(negedge clock);
    chk_i.check_reset_state();
    fd = $fopen("dv/rob_tests.txt", "r");
    if (fd == 0) begin
      chk_i.report_error("Could not open the tests file");
      abort = 1'b1;
    end
    while (!abort && fd != 0 && !$feof(fd)) begin
      code = $fgets(line, fd);
      if (code == 0 || line.len() < 2 || line[0] == "#") begin
        continue;
      end
      code = $sscanf(line, "%c %h %h %h %h %h %h %h %h %h", cmd, f0, f1, f2, f3, f4, f5, f6,
                     f7, f8);
      if (cmd == "D" || cmd == "C" || cmd == "T" || cmd == "F") begin
        wait_background();
      end
      case (cmd)
        "D": begin
          if (f3[0]) begin
            bg_dest       = f0[4:0];
            bg_dest_valid = f1[0];
            bg_slot       = f2[4:0];
            bg_busy       = 1'b1;
            fork
              begin
                dispatch(bg_dest, bg_dest_valid, bg_slot, 1'b1);
                bg_busy = 1'b0;
              end
            join_none
          end else begin
            dispatch(f0[4:0], f1[0], f2[4:0], 1'b0);
          end
        end
        "W": writeback(f0[4:0], f1);
        "F": flush(f0[4:0]);
        "Q": begin
          @(posedge clock);
          query_slot_i <= f0[4:0];
          src_a_i      <= f1[4:0];
          src_b_i      <= f2[4:0];
          @(negedge clock);
          chk_i.check_query(f3, f4[0], f5, f6, f7[0], f8);
        end
        "R": chk_i.expect_retire(f0[4:0], f1);
        "C": wait_empty();
        "T": begin
          @(posedge clock);
          chk_i.end_test();
        end
        default: chk_i.report_error($sformatf("Unknown command in tests file: %s", line));
      endcase
      // Idle gap between commands
      repeat ($urandom_range(3)) @(posedge clock);
    end
    if (fd != 0) begin
      $fclose(fd);
    end
    wait_background();
    $display("%0d tests, %0d checks, %0d errors", chk_i.tests, chk_i.checks, chk_i.errors);
    if (chk_i.errors == 0 && !abort) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: dv/rob_tests.txt
# D dest dest_valid exp_slot stall | W slot data | F slot | R reg data | C | T
# Q qslot src_a src_b value_a ready_a tag_a value_b ready_b tag_b (all hex)
D 01 1 00 0
D 02 1 01 0
D 03 1 02 0
R 01 00000011
R 02 00000022
R 03 00000033
W 00 00000011
W 01 00000022
W 02 00000033
C
T
D 04 1 03 0
D 05 1 04 0
D 06 1 05 0
R 04 00000044
R 05 00000055
R 06 00000066
W 05 00000066
W 04 00000055
W 03 00000044
C
T
D 07 1 06 0
D 07 1 07 0
D 08 1 08 0
Q 09 07 08 00000000 0 07 00000000 0 08
Q 08 07 01 00000000 0 07 00000011 1 00
Q 07 07 00 00000000 0 06 00000000 1 00
W 07 0000aaaa
Q 09 07 00 0000aaaa 1 07 00000000 1 00
R 07 0000bbbb
R 07 0000aaaa
R 08 0000cccc
W 06 0000bbbb
W 08 0000cccc
C
Q 09 07 08 0000aaaa 1 00 0000cccc 1 00
T
D 09 1 09 0
D 0a 1 0a 0
D 0b 1 0b 0
F 09
W 0b deadbeef
D 0c 1 0a 0
R 09 00000099
R 0c 000000cc
W 09 00000099
W 0a 000000cc
C
Q 0b 0a 0b 00000000 1 00 00000000 1 00
T
D 10 1 0b 0
D 11 1 0c 0
D 12 1 0d 0
D 13 1 0e 0
D 14 1 0f 0
D 15 1 00 0
D 16 1 01 0
D 17 1 02 0
D 18 1 03 0
D 19 1 04 0
D 1a 1 05 0
D 1b 1 06 0
D 1c 1 07 0
D 1d 1 08 0
D 1e 1 09 0
D 1f 1 0a 0
D 01 1 0b 1
R 10 00000100
W 0b 00000100
F 0c
R 11 00000111
W 0c 00000111
C
T
D 03 0 0d 0
Q 0e 03 02 00000033 1 00 00000022 1 00
R 03 0000dddd
W 0d 0000dddd
C
Q 0e 03 02 00000033 1 00 00000022 1 00
T

// File: hw/arch_regfile.sv
module arch_regfile (
  input  logic           clock,
  input  logic           reset_n,
  input  logic           we_i,
  input  rob_pkg::areg_t waddr_i,
  input  rob_pkg::data_t wdata_i,
  input  rob_pkg::areg_t raddr_a_i,
  input  rob_pkg::areg_t raddr_b_i,
  output rob_pkg::data_t rdata_a_o,
  output rob_pkg::data_t rdata_b_o
);

  rob_pkg::data_t regs_q [32];

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Register 0 always reads as zero
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

endmodule

// File: hw/dispatch_ctrl.sv
module dispatch_ctrl #(
  parameter int DEPTH = 16
) (
  input  logic           clock,
  input  logic           reset_n,
  input  logic           disp_req_i,
  input  rob_pkg::areg_t disp_dest_i,
  input  logic           disp_dest_valid_i,
  input  logic           full_i,
  input  rob_pkg::slot_t tail_slot_i,
  output logic           disp_ack_o,
  output rob_pkg::slot_t disp_slot_o,
  output logic           reserve_o,
  output rob_pkg::areg_t reserve_dest_o,
  output logic           reserve_dest_valid_o
);

  localparam int PW = $clog2(DEPTH);

  rob_pkg::disp_state_t state_q;
  rob_pkg::disp_state_t state_d;
  logic [PW-1:0]        slot_q;

  // One reservation per handshake, held off while the buffer is full
  assign reserve_o            = (state_q == rob_pkg::D_IDLE) && disp_req_i && !full_i;
  assign reserve_dest_o       = disp_dest_i;
  assign reserve_dest_valid_o = disp_dest_valid_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      rob_pkg::D_IDLE: begin
        if (reserve_o) begin
          state_d = rob_pkg::D_ACK;
        end
      end
      rob_pkg::D_ACK: begin
        state_d = disp_req_i ? rob_pkg::D_WAIT_LOW : rob_pkg::D_IDLE;
      end
      rob_pkg::D_WAIT_LOW: begin
        if (!disp_req_i) begin
          state_d = rob_pkg::D_IDLE;
        end
      end
      default: state_d = rob_pkg::D_IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      state_q <= rob_pkg::D_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Slot held for the whole ack phase
  always_ff @(posedge clock) begin
    if (reserve_o) begin
      slot_q <= tail_slot_i[PW-1:0];
    end
  end

  assign disp_ack_o  = (state_q != rob_pkg::D_IDLE);
  assign disp_slot_o = rob_pkg::slot_t'(slot_q);

endmodule

// File: hw/operand_resolve.sv
module operand_resolve (
  input  logic           a_hit_i,
  input  logic           a_done_i,
  input  rob_pkg::data_t a_data_i,
  input  rob_pkg::slot_t a_slot_i,
  input  logic           b_hit_i,
  input  logic           b_done_i,
  input  rob_pkg::data_t b_data_i,
  input  rob_pkg::slot_t b_slot_i,
  input  rob_pkg::data_t rf_a_i,
  input  rob_pkg::data_t rf_b_i,
  output rob_pkg::data_t value_a_o,
  output rob_pkg::data_t value_b_o,
  output logic           ready_a_o,
  output logic           ready_b_o,
  output rob_pkg::slot_t tag_a_o,
  output rob_pkg::slot_t tag_b_o
);

  // Buffer result if produced, regfile if no producer, else wait on tag
  function automatic void resolve(input logic hit, input logic done,
                                  input rob_pkg::data_t rob_data, input rob_pkg::slot_t slot,
                                  input rob_pkg::data_t rf_data, output rob_pkg::data_t value,
                                  output logic ready, output rob_pkg::slot_t tag);
    value = '0;
    ready = 1'b1;
    tag   = '0;
    if (!hit) begin
      value = rf_data;
    end else begin
      tag = slot;
      if (done) begin
        value = rob_data;
      end else begin
        ready = 1'b0;
      end
    end
  endfunction

  always_comb begin
    resolve(a_hit_i, a_done_i, a_data_i, a_slot_i, rf_a_i, value_a_o, ready_a_o, tag_a_o);
    resolve(b_hit_i, b_done_i, b_data_i, b_slot_i, rf_b_i, value_b_o, ready_b_o, tag_b_o);
  end

endmodule

// File: hw/retire_ctrl.sv
module retire_ctrl #(
  parameter int DEPTH = 16
) (
  input  logic           clock,
  input  logic           reset_n,
  input  logic           head_valid_i,
  input  rob_pkg::areg_t head_dest_i,
  input  logic           head_dest_valid_i,
  input  rob_pkg::data_t head_data_i,
  output logic           pop_o,
  output logic           rf_we_o,
  output rob_pkg::areg_t rf_waddr_o,
  output rob_pkg::data_t rf_wdata_o,
  output logic           retire_valid_o,
  output rob_pkg::areg_t retire_reg_o,
  output rob_pkg::data_t retire_data_o
);

  // Slot fields are carried in rob_pkg::slot_t, which bounds DEPTH
  if (DEPTH < 4 || DEPTH > (2 ** rob_pkg::MAX_DEPTH_LOG2) ||
      (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
    $error("retire_ctrl: DEPTH %0d is not a power of two from 4 to 32", DEPTH);
  end

  logic           retire_valid_q;
  rob_pkg::areg_t retire_reg_q;
  rob_pkg::data_t retire_data_q;

  // A written head leaves on the next edge, one entry per cycle
  assign pop_o = head_valid_i;

  // Register 0 and non-writing entries leave the register file alone
  assign rf_we_o    = head_valid_i && head_dest_valid_i && (head_dest_i != '0);
  assign rf_waddr_o = head_dest_i;
  assign rf_wdata_o = head_data_i;

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      retire_valid_q <= 1'b0;
    end else begin
      retire_valid_q <= pop_o;
    end
  end

  always_ff @(posedge clock) begin
    if (pop_o) begin
      retire_reg_q  <= head_dest_i;
      retire_data_q <= head_data_i;
    end
  end

  assign retire_valid_o = retire_valid_q;
  assign retire_reg_o   = retire_reg_q;
  assign retire_data_o  = retire_data_q;

endmodule

// File: hw/rob_core.sv
module rob_core #(
  parameter int DEPTH = 16
) (
  input  logic           clock,
  input  logic           reset_n,
  input  logic           reserve_i,
  input  rob_pkg::areg_t reserve_dest_i,
  input  logic           reserve_dest_valid_i,
  output rob_pkg::slot_t tail_slot_o,
  output logic           full_o,
  output logic           empty_o,
  input  logic           wb_valid_i,
  input  rob_pkg::slot_t wb_slot_i,
  input  rob_pkg::data_t wb_data_i,
  input  logic           flush_i,
  input  rob_pkg::slot_t flush_slot_i,
  input  logic           pop_i,
  output logic           head_valid_o,
  output rob_pkg::areg_t head_dest_o,
  output logic           head_dest_valid_o,
  output rob_pkg::data_t head_data_o,
  input  rob_pkg::slot_t query_slot_i,
  input  rob_pkg::areg_t src_a_i,
  input  rob_pkg::areg_t src_b_i,
  output logic           a_hit_o,
  output logic           a_done_o,
  output rob_pkg::data_t a_data_o,
  output rob_pkg::slot_t a_slot_o,
  output logic           b_hit_o,
  output logic           b_done_o,
  output rob_pkg::data_t b_data_o,
  output rob_pkg::slot_t b_slot_o
);

  localparam int PW = $clog2(DEPTH);
  localparam int CW = $clog2(DEPTH + 1);

  typedef logic [PW-1:0] ptr_t;
  typedef logic [CW-1:0] cnt_t;

  rob_pkg::areg_t dest_q       [DEPTH];
  logic           dest_valid_q [DEPTH];
  logic           written_q    [DEPTH];
  rob_pkg::data_t result_q     [DEPTH];

  ptr_t head_q;
  ptr_t tail_q;
  cnt_t count_q;

  ptr_t wb_idx;
  ptr_t flush_idx;
  ptr_t query_idx;
  ptr_t wb_off;
  ptr_t flush_off;
  ptr_t a_idx;
  ptr_t b_idx;
  logic do_reserve;
  logic wb_keep;

  assign wb_idx    = wb_slot_i[PW-1:0];
  assign flush_idx = flush_slot_i[PW-1:0];
  assign query_idx = query_slot_i[PW-1:0];

  // Distance from the head, in program order
  assign wb_off    = wb_idx - head_q;
  assign flush_off = flush_idx - head_q;

  assign full_o      = (count_q == cnt_t'(DEPTH));
  assign empty_o     = (count_q == '0);
  assign tail_slot_o = rob_pkg::slot_t'(tail_q);

  // Flush wins over a reservation on the same edge
  assign do_reserve = reserve_i && !full_o && !flush_i;

  // Only live slots take a result, and none that this flush discards
  assign wb_keep = wb_valid_i && (cnt_t'(wb_off) < count_q) &&
                   (!flush_i || (wb_off <= flush_off));

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (pop_i) begin
        head_q <= head_q + 1'b1;
      end
      if (flush_i) begin
        // Keep the flush slot itself, drop everything younger
        tail_q  <= flush_idx + 1'b1;
        count_q <= cnt_t'(flush_off) + 1'b1 - cnt_t'(pop_i);
      end else begin
        if (do_reserve) begin
          tail_q <= tail_q + 1'b1;
        end
        count_q <= count_q + cnt_t'(do_reserve) - cnt_t'(pop_i);
      end
    end
  end

  always_ff @(posedge clock or negedge reset_n) begin
    if (!reset_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        written_q[i] <= 1'b0;
      end
    end else begin
      if (do_reserve) begin
        written_q[tail_q] <= 1'b0;
      end
      if (wb_keep) begin
        written_q[wb_idx] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (do_reserve) begin
      dest_q[tail_q]       <= reserve_dest_i;
      dest_valid_q[tail_q] <= reserve_dest_valid_i;
    end
    if (wb_keep) begin
      result_q[wb_idx] <= wb_data_i;
    end
  end

  assign head_valid_o      = !empty_o && written_q[head_q];
  assign head_dest_o       = dest_q[head_q];
  assign head_dest_valid_o = dest_valid_q[head_q];
  assign head_data_o       = result_q[head_q];

  // Newest producer older than the query slot, walking back to the head
  function automatic void find_producer(input rob_pkg::areg_t src, output logic hit,
                                        output ptr_t idx);
    ptr_t q_off;
    ptr_t k;
    q_off = query_idx - head_q;
    hit   = 1'b0;
    idx   = '0;
    if (cnt_t'(q_off) <= count_q) begin
      for (int i = 1; i < DEPTH; i++) begin
        k = query_idx - ptr_t'(i);
        if (!hit && (i <= int'(q_off)) && dest_valid_q[k] && (dest_q[k] == src)) begin
          hit = 1'b1;
          idx = k;
        end
      end
    end
  endfunction

  always_comb begin
    find_producer(src_a_i, a_hit_o, a_idx);
    find_producer(src_b_i, b_hit_o, b_idx);
  end

  assign a_done_o = a_hit_o && written_q[a_idx];
  assign a_data_o = result_q[a_idx];
  assign a_slot_o = rob_pkg::slot_t'(a_idx);
  assign b_done_o = b_hit_o && written_q[b_idx];
  assign b_data_o = result_q[b_idx];
  assign b_slot_o = rob_pkg::slot_t'(b_idx);

endmodule

// File: hw/rob_pkg.sv
package rob_pkg;

  // Upper bound on the slot index width, so DEPTH may reach 32
  localparam int MAX_DEPTH_LOG2 = 5;

  // Result and register values
  typedef logic [31:0] data_t;

  // Architectural register number
  typedef logic [4:0] areg_t;

  // Slot index, only the low $clog2(DEPTH) bits are used
  typedef logic [MAX_DEPTH_LOG2-1:0] slot_t;

  // Dispatch handshake states
  typedef enum logic [1:0] {
    D_IDLE,
    D_ACK,
    D_WAIT_LOW
  } disp_state_t;

endpackage

// File: hw/rob_top.sv
module rob_top #(
  parameter int DEPTH = 16
) (
  input  logic           clock,
  input  logic           reset_n,
  input  logic           disp_req_i,
  input  rob_pkg::areg_t disp_dest_i,
  input  logic           disp_dest_valid_i,
  output logic           disp_ack_o,
  output rob_pkg::slot_t disp_slot_o,
  input  logic           wb_valid_i,
  input  rob_pkg::slot_t wb_slot_i,
  input  rob_pkg::data_t wb_data_i,
  input  logic           flush_i,
  input  rob_pkg::slot_t flush_slot_i,
  input  rob_pkg::slot_t query_slot_i,
  input  rob_pkg::areg_t src_a_i,
  input  rob_pkg::areg_t src_b_i,
  output rob_pkg::data_t value_a_o,
  output rob_pkg::data_t value_b_o,
  output logic           ready_a_o,
  output logic           ready_b_o,
  output rob_pkg::slot_t tag_a_o,
  output rob_pkg::slot_t tag_b_o,
  output logic           retire_valid_o,
  output rob_pkg::areg_t retire_reg_o,
  output rob_pkg::data_t retire_data_o,
  output logic           full_o,
  output logic           empty_o
);

  logic           reserve;
  rob_pkg::areg_t reserve_dest;
  logic           reserve_dest_valid;
  rob_pkg::slot_t tail_slot;

  logic           head_valid;
  rob_pkg::areg_t head_dest;
  logic           head_dest_valid;
  rob_pkg::data_t head_data;
  logic           retire_pop;

  logic           a_hit;
  logic           a_done;
  rob_pkg::data_t a_data;
  rob_pkg::slot_t a_slot;
  logic           b_hit;
  logic           b_done;
  rob_pkg::data_t b_data;
  rob_pkg::slot_t b_slot;

  logic           rf_we;
  rob_pkg::areg_t rf_waddr;
  rob_pkg::data_t rf_wdata;
  rob_pkg::data_t rf_a;
  rob_pkg::data_t rf_b;

  dispatch_ctrl #(
    .DEPTH(DEPTH)
  ) dispatch_i (
    .clock               (clock),
    .reset_n             (reset_n),
    .disp_req_i          (disp_req_i),
    .disp_dest_i         (disp_dest_i),
    .disp_dest_valid_i   (disp_dest_valid_i),
    .full_i              (full_o),
    .tail_slot_i         (tail_slot),
    .disp_ack_o          (disp_ack_o),
    .disp_slot_o         (disp_slot_o),
    .reserve_o           (reserve),
    .reserve_dest_o      (reserve_dest),
    .reserve_dest_valid_o(reserve_dest_valid)
  );

  rob_core #(
    .DEPTH(DEPTH)
  ) core_i (
    .clock               (clock),
    .reset_n             (reset_n),
    .reserve_i           (reserve),
    .reserve_dest_i      (reserve_dest),
    .reserve_dest_valid_i(reserve_dest_valid),
    .tail_slot_o         (tail_slot),
    .full_o              (full_o),
    .empty_o             (empty_o),
    .wb_valid_i          (wb_valid_i),
    .wb_slot_i           (wb_slot_i),
    .wb_data_i           (wb_data_i),
    .flush_i             (flush_i),
    .flush_slot_i        (flush_slot_i),
    .pop_i               (retire_pop),
    .head_valid_o        (head_valid),
    .head_dest_o         (head_dest),
    .head_dest_valid_o   (head_dest_valid),
    .head_data_o         (head_data),
    .query_slot_i        (query_slot_i),
    .src_a_i             (src_a_i),
    .src_b_i             (src_b_i),
    .a_hit_o             (a_hit),
    .a_done_o            (a_done),
    .a_data_o            (a_data),
    .a_slot_o            (a_slot),
    .b_hit_o             (b_hit),
    .b_done_o            (b_done),
    .b_data_o            (b_data),
    .b_slot_o            (b_slot)
  );

  retire_ctrl #(
    .DEPTH(DEPTH)
  ) retire_i (
    .clock            (clock),
    .reset_n          (reset_n),
    .head_valid_i     (head_valid),
    .head_dest_i      (head_dest),
    .head_dest_valid_i(head_dest_valid),
    .head_data_i      (head_data),
    .pop_o            (retire_pop),
    .rf_we_o          (rf_we),
    .rf_waddr_o       (rf_waddr),
    .rf_wdata_o       (rf_wdata),
    .retire_valid_o   (retire_valid_o),
    .retire_reg_o     (retire_reg_o),
    .retire_data_o    (retire_data_o)
  );

  arch_regfile regfile_i (
    .clock    (clock),
    .reset_n  (reset_n),
    .we_i     (rf_we),
    .waddr_i  (rf_waddr),
    .wdata_i  (rf_wdata),
    .raddr_a_i(src_a_i),
    .raddr_b_i(src_b_i),
    .rdata_a_o(rf_a),
    .rdata_b_o(rf_b)
  );

  operand_resolve resolve_i (
    .a_hit_i  (a_hit),
    .a_done_i (a_done),
    .a_data_i (a_data),
    .a_slot_i (a_slot),
    .b_hit_i  (b_hit),
    .b_done_i (b_done),
    .b_data_i (b_data),
    .b_slot_i (b_slot),
    .rf_a_i   (rf_a),
    .rf_b_i   (rf_b),
    .value_a_o(value_a_o),
    .value_b_o(value_b_o),
    .ready_a_o(ready_a_o),
    .ready_b_o(ready_b_o),
    .tag_a_o  (tag_a_o),
    .tag_b_o  (tag_b_o)
  );

endmodule

// File: tb.f
hw/rob_pkg.sv
hw/rob_core.sv
hw/dispatch_ctrl.sv
hw/retire_ctrl.sv
hw/arch_regfile.sv
hw/operand_resolve.sv
hw/rob_top.sv
dv/rob_assert.sv
dv/rob_checker.sv
dv/rob_tb.sv
